// File: Bender.yml
package:
  name: soc_ifc

sources:
  - files:
      - hdl/soc_ifc_pkg.sv
      - hdl/soc_ifc_csr_pkg.sv
      - hdl/soc_ifc_arb.sv
      - hdl/soc_ifc_mbox.sv
      - hdl/soc_ifc_regs.sv
      - hdl/soc_ifc_top.sv
  - target: test
    files:
      - dv/soc_ifc_checker.sv
      - dv/soc_ifc_tb.sv

// File: dv/soc_ifc_checker.sv
`timescale 1ns/1ps

module soc_ifc_checker import soc_ifc_pkg::*; (
    input  logic clk,
    input  logic rst_b,
    input  logic uc_req_dv,
    input  soc_ifc_addr_t uc_req_addr,
    input  soc_ifc_data_t uc_req_wdata,
    input  logic uc_req_write,
    input  logic uc_req_hold,
    input  soc_ifc_data_t uc_rdata,
    input  logic uc_error,
    input  logic soc_req_dv,
    input  soc_ifc_addr_t soc_req_addr,
    input  soc_ifc_data_t soc_req_wdata,
    input  logic soc_req_write,
    input  soc_ifc_user_t soc_req_user,
    input  logic soc_req_hold,
    input  soc_ifc_data_t soc_rdata,
    input  logic soc_error,
    // Arbiter ownership of each target
    input  logic uc_owns_mbox,
    input  logic uc_owns_reg,
    input  logic soc_wins_mbox,
    input  logic soc_wins_reg
);

    int unsigned fail_count = 0;
    logic uc_unmapped;
    logic soc_unmapped;

    // An address outside all three windows belongs to no target
    assign uc_unmapped = !(uc_req_addr inside {[MBOX_REG_START_ADDR:MBOX_REG_END_ADDR],
        [MBOX_DIR_START_ADDR:MBOX_DIR_END_ADDR], [SOC_IFC_REG_START_ADDR:SOC_IFC_REG_END_ADDR]});
    assign soc_unmapped = !(soc_req_addr inside {[MBOX_REG_START_ADDR:MBOX_REG_END_ADDR],
        [MBOX_DIR_START_ADDR:MBOX_DIR_END_ADDR], [SOC_IFC_REG_START_ADDR:SOC_IFC_REG_END_ADDR]});

    // First cycle out of reset, nobody is held
    hold_low_after_reset: assert property (@(posedge clk)
        $rose(rst_b) |-> !uc_req_hold && !soc_req_hold)
    else begin
        fail_count++;
        $error("hold is high in the first cycle after reset");
    end

    // An idle requester sees no hold, no error and zero data
    idle_outputs_quiet: assert property (@(posedge clk) disable iff (!rst_b)
        (uc_req_dv || (!uc_req_hold && !uc_error && uc_rdata == '0)) &&
        (soc_req_dv || (!soc_req_hold && !soc_error && soc_rdata == '0)))
    else begin
        fail_count++;
        $error("idle requester sees hold, error or nonzero rdata");
    end

    // Each requester owns at most one target per cycle
    single_rdata_source: assert property (@(posedge clk) disable iff (!rst_b)
        !(uc_owns_mbox && uc_owns_reg) && !(soc_wins_mbox && soc_wins_reg))
    else begin
        fail_count++;
        $error("rdata of one requester comes from two targets");
    end

    unmapped_error_now: assert property (@(posedge clk) disable iff (!rst_b)
        (!(uc_req_dv && uc_unmapped) || (uc_error && !uc_req_hold)) &&
        (!(soc_req_dv && soc_unmapped) || (soc_error && !soc_req_hold)))
    else begin
        fail_count++;
        $error("unmapped address did not complete with error at once");
    end

    // A held request must keep dv and every field until it completes
    uc_fields_stable: assert property (@(posedge clk) disable iff (!rst_b)
        uc_req_dv && uc_req_hold |=> uc_req_dv && $stable(uc_req_addr) &&
        $stable(uc_req_wdata) && $stable(uc_req_write))
    else begin
        fail_count++;
        $error("uc request changed while held");
    end

    soc_fields_stable: assert property (@(posedge clk) disable iff (!rst_b)
        soc_req_dv && soc_req_hold |=> soc_req_dv && $stable(soc_req_addr) &&
        $stable(soc_req_wdata) && $stable(soc_req_write) && $stable(soc_req_user))
    else begin
        fail_count++;
        $error("soc request changed while held");
    end

endmodule

bind soc_ifc_top soc_ifc_checker checker_i (
    .*,
    .uc_owns_mbox(arb_i.uc_owns_mbox),
    .uc_owns_reg(arb_i.uc_owns_reg),
    .soc_wins_mbox(arb_i.soc_wins_mbox),
    .soc_wins_reg(arb_i.soc_wins_reg)
);

// File: dv/soc_ifc_tb.sv
`timescale 1ns/1ps

module soc_ifc_tb import soc_ifc_pkg::*, soc_ifc_csr_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    // Accesses issued by the test sequence below, used to size the watchdog
    localparam int NUM_ACCESSES = 47;
    localparam soc_ifc_addr_t LOCK_ADDR = MBOX_REG_START_ADDR + MBOX_LOCK_OFFSET;
    localparam soc_ifc_addr_t OWNER_ADDR = MBOX_REG_START_ADDR + MBOX_USER_OFFSET;

    logic clk;
    logic rst_b;
    logic uc_req_dv;
    soc_ifc_addr_t uc_req_addr;
    soc_ifc_data_t uc_req_wdata;
    logic uc_req_write;
    logic uc_req_hold;
    soc_ifc_data_t uc_rdata;
    logic uc_error;
    logic soc_req_dv;
    soc_ifc_addr_t soc_req_addr;
    soc_ifc_data_t soc_req_wdata;
    logic soc_req_write;
    soc_ifc_user_t soc_req_user;
    logic soc_req_hold;
    soc_ifc_data_t soc_rdata;
    logic soc_error;

    // Reference model of every register and memory the fabric reaches
    int unsigned data_errors;
    soc_ifc_data_t scratch_m [REG_NUM_SCRATCH];
    soc_ifc_user_t valid_user_m [NUM_VALID_USERS];
    soc_ifc_data_t sram_m [MBOX_DEPTH];
    logic lock_m;
    logic owner_is_soc_m;
    soc_ifc_user_t owner_user_m;
    soc_ifc_user_t good_user;
    soc_ifc_user_t bad_user;
    soc_ifc_data_t d;
    int idx;

    soc_ifc_top dut_i (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic soc_ifc_addr_t reg_addr(input csr_offset_t base, input int i);
        return SOC_IFC_REG_START_ADDR + soc_ifc_addr_t'(base) + soc_ifc_addr_t'(4 * i);
    endfunction

    function automatic soc_ifc_addr_t sram_addr(input int i);
        return MBOX_DIR_START_ADDR + soc_ifc_addr_t'(4 * i);
    endfunction

    function automatic logic user_allowed(input soc_ifc_user_t user);
        logic hit;
        hit = 1'b0;
        for (int j = 0; j < NUM_VALID_USERS; j++) begin
            hit |= (valid_user_m[j] == user);
        end
        return hit;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            data_errors++;
            $display("[ERROR] %0t %s expected 0x%08h actual 0x%08h", $time, name,
                     expected, actual);
        end
    endtask

    // Runs one uc access from a falling edge, outputs are sampled a quarter period later
    task automatic uc_check(input soc_ifc_addr_t addr, input soc_ifc_data_t wdata,
                            input logic write, input soc_ifc_data_t exp_rdata,
                            input logic exp_error, input int exp_waits);
        int waits;
        waits = 0;
        uc_req_dv = 1'b1;
        uc_req_addr = addr;
        uc_req_wdata = wdata;
        uc_req_write = write;
        #(CLK_PERIOD/4);
        while (uc_req_hold) begin
            @(negedge clk);
            waits++;
            #(CLK_PERIOD/4);
        end
        check_value("uc_error", 32'(exp_error), 32'(uc_error));
        check_value("uc_req_hold cycles", exp_waits, waits);
        if (!write && !exp_error) begin
            check_value("uc_rdata", exp_rdata, uc_rdata);
        end
        @(negedge clk);
        uc_req_dv = 1'b0;
    endtask

    task automatic soc_check(input soc_ifc_addr_t addr, input soc_ifc_data_t wdata,
                             input logic write, input soc_ifc_user_t user,
                             input soc_ifc_data_t exp_rdata, input logic exp_error,
                             input int exp_waits);
        int waits;
        waits = 0;
        soc_req_dv = 1'b1;
        soc_req_addr = addr;
        soc_req_wdata = wdata;
        soc_req_write = write;
        soc_req_user = user;
        #(CLK_PERIOD/4);
        while (soc_req_hold) begin
            @(negedge clk);
            waits++;
            #(CLK_PERIOD/4);
        end
        check_value("soc_error", 32'(exp_error), 32'(soc_error));
        check_value("soc_req_hold cycles", exp_waits, waits);
        if (!write && !exp_error) begin
            check_value("soc_rdata", exp_rdata, soc_rdata);
        end
        @(negedge clk);
        soc_req_dv = 1'b0;
    endtask

    // A lock read returns the lock bit and hands a free lock to the reader
    task automatic lock_read(input logic from_soc, input soc_ifc_user_t user);
        if (from_soc) begin
            soc_check(LOCK_ADDR, '0, 1'b0, user, 32'(lock_m), 1'b0, 0);
        end else begin
            uc_check(LOCK_ADDR, '0, 1'b0, 32'(lock_m), 1'b0, 0);
        end
        if (!lock_m) begin
            lock_m = 1'b1;
            owner_is_soc_m = from_soc;
            owner_user_m = user;
        end
    endtask

    // Only the lock holder may clear the lock, anyone else gets error
    task automatic lock_release(input logic from_soc, input soc_ifc_user_t user);
        logic owner;
        owner = lock_m && (owner_is_soc_m == from_soc) && (!from_soc || user == owner_user_m);
        if (from_soc) begin
            soc_check(LOCK_ADDR, '0, 1'b1, user, '0, !owner, 0);
        end else begin
            uc_check(LOCK_ADDR, '0, 1'b1, '0, !owner, 0);
        end
        if (owner) begin
            lock_m = 1'b0;
        end
    endtask

    initial begin
        #(NUM_ACCESSES * 200 * CLK_PERIOD);
        $display("Run timed out after %0d cycles before the tests finished", NUM_ACCESSES * 200);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h8ffc));
        rst_b = 1'b0;
        uc_req_dv = 1'b0;
        uc_req_addr = '0;
        uc_req_wdata = '0;
        uc_req_write = 1'b0;
        soc_req_dv = 1'b0;
        soc_req_addr = '0;
        soc_req_wdata = '0;
        soc_req_write = 1'b0;
        soc_req_user = '0;
        data_errors = 0;
        lock_m = 1'b0;
        owner_is_soc_m = 1'b0;
        owner_user_m = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_b = 1'b1;

        // Register block, scratch write then read back with no hold
        for (int i = 0; i < REG_NUM_SCRATCH; i++) begin
            scratch_m[i] = $urandom;
            uc_check(reg_addr(REG_SCRATCH_OFFSET, i), scratch_m[i], 1'b1, '0, 1'b0, 0);
        end
        for (int i = 0; i < REG_NUM_SCRATCH; i++) begin
            uc_check(reg_addr(REG_SCRATCH_OFFSET, i), '0, 1'b0, scratch_m[i], 1'b0, 0);
        end
        // Valid-user words show their reset value before being programmed
        for (int j = 0; j < NUM_VALID_USERS; j++) begin
            uc_check(reg_addr(REG_VALID_USER_OFFSET, j), '0, 1'b0, VALID_USER_RESET, 1'b0, 0);
            valid_user_m[j] = $urandom;
            uc_check(reg_addr(REG_VALID_USER_OFFSET, j), valid_user_m[j], 1'b1, '0, 1'b0, 0);
            uc_check(reg_addr(REG_VALID_USER_OFFSET, j), '0, 1'b0, valid_user_m[j], 1'b0, 0);
        end
        uc_check(reg_addr(REG_VALID_USER_OFFSET, NUM_VALID_USERS), '0, 1'b0, '0, 1'b1, 0);
        uc_check(reg_addr(8'hFC, 0), '0, 1'b1, '0, 1'b1, 0);

        // Direct SRAM, writes finish at once and reads wait one cycle
        good_user = valid_user_m[1];
        for (int k = 0; k < 3; k++) begin
            idx = $urandom_range(MBOX_DEPTH - 1, 0);
            sram_m[idx] = $urandom;
            uc_check(sram_addr(idx), sram_m[idx], 1'b1, '0, 1'b0, 0);
            uc_check(sram_addr(idx), '0, 1'b0, sram_m[idx], 1'b0, 1);
        end
        soc_check(sram_addr(0), '0, 1'b0, good_user, '0, 1'b1, 0);

        // User filter and lock, an unlisted user is refused before the mailbox
        bad_user = good_user;
        while (user_allowed(bad_user)) begin
            bad_user = $urandom;
        end
        soc_check(LOCK_ADDR, '0, 1'b0, bad_user, '0, 1'b1, 0);
        lock_read(1'b1, good_user);
        lock_read(1'b1, good_user);
        uc_check(OWNER_ADDR, '0, 1'b0, owner_user_m, 1'b0, 0);
        lock_release(1'b0, '0);
        lock_release(1'b1, good_user);
        lock_read(1'b0, '0);
        lock_release(1'b0, '0);
        lock_read(1'b1, good_user);

        // Collisions on the register block, uc wins the first and soc the next
        d = $urandom;
        scratch_m[2] = d;
        fork
            uc_check(reg_addr(REG_SCRATCH_OFFSET, 2), d, 1'b1, '0, 1'b0, 0);
            soc_check(reg_addr(REG_SCRATCH_OFFSET, 2), '0, 1'b0, good_user, scratch_m[2],
                      1'b0, 1);
        join
        d = $urandom;
        scratch_m[3] = d;
        fork
            uc_check(reg_addr(REG_SCRATCH_OFFSET, 3), '0, 1'b0, scratch_m[3], 1'b0, 1);
            soc_check(reg_addr(REG_SCRATCH_OFFSET, 3), d, 1'b1, good_user, '0, 1'b0, 0);
        join

        // Addresses outside every window
        uc_check(18'h2_0000, '0, 1'b0, '0, 1'b1, 0);
        soc_check(18'h3_FF00, '0, 1'b1, good_user, '0, 1'b1, 0);

        repeat (2) @(negedge clk);
        $display("Error counts: %0d data mismatches, %0d assertion failures", data_errors,
                 dut_i.checker_i.fail_count);
        if (data_errors == 0 && dut_i.checker_i.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: hdl/soc_ifc_arb.sv
`timescale 1ns/1ps

module soc_ifc_arb import soc_ifc_pkg::*; (
    input  logic clk,
    input  logic rst_b,

    input  soc_ifc_user_t [NUM_VALID_USERS-1:0] valid_users,

    // Internal microcontroller requester
    input  logic uc_req_dv,
    input  soc_ifc_addr_t uc_req_addr,
    input  soc_ifc_data_t uc_req_wdata,
    input  logic uc_req_write,
    output logic uc_req_hold,
    output soc_ifc_data_t uc_rdata,
    output logic uc_error,

    // External SoC requester
    input  logic soc_req_dv,
    input  soc_ifc_addr_t soc_req_addr,
    input  soc_ifc_data_t soc_req_wdata,
    input  logic soc_req_write,
    input  soc_ifc_user_t soc_req_user,
    output logic soc_req_hold,
    output soc_ifc_data_t soc_rdata,
    output logic soc_error,

    // Mailbox target
    output logic mbox_req_dv,
    output logic mbox_dir_req_dv,
    output soc_ifc_addr_t mbox_req_addr,
    output soc_ifc_data_t mbox_req_wdata,
    output logic mbox_req_write,
    output soc_ifc_user_t mbox_req_user,
    input  logic mbox_req_hold,
    input  soc_ifc_data_t mbox_rdata,
    input  logic mbox_error,

    // Register block target
    output logic reg_req_dv,
    output soc_ifc_addr_t reg_req_addr,
    output soc_ifc_data_t reg_req_wdata,
    output logic reg_req_write,
    input  logic reg_req_hold,
    input  soc_ifc_data_t reg_rdata,
    input  logic reg_error
);

    // User attribute that the mailbox sees on every uc access
    localparam soc_ifc_user_t UC_USER = 32'h0000_0000;

    logic soc_has_priority;
    logic soc_user_ok;
    logic uc_mbox_reg_req;
    logic uc_mbox_dir_req;
    logic uc_mbox_req;
    logic uc_reg_req;
    logic soc_mbox_req;
    logic soc_reg_req;
    logic mbox_collision;
    logic reg_collision;
    logic soc_wins_mbox;
    logic soc_wins_reg;
    logic uc_owns_mbox;
    logic uc_owns_reg;

    // The SoC user must match one of the programmed valid users
    always_comb begin
        soc_user_ok = 1'b0;
        for (int i = 0; i < NUM_VALID_USERS; i++) begin
            soc_user_ok |= (soc_req_user == valid_users[i]);
        end
    end

    // Decode of the uc address against every window it may use
    assign uc_mbox_reg_req = uc_req_dv &
        (uc_req_addr inside {[MBOX_REG_START_ADDR:MBOX_REG_END_ADDR]});
    assign uc_mbox_dir_req = uc_req_dv &
        (uc_req_addr inside {[MBOX_DIR_START_ADDR:MBOX_DIR_END_ADDR]});
    assign uc_mbox_req = uc_mbox_reg_req | uc_mbox_dir_req;
    assign uc_reg_req = uc_req_dv &
        (uc_req_addr inside {[SOC_IFC_REG_START_ADDR:SOC_IFC_REG_END_ADDR]});

    // The soc side never reaches the direct window, so a hit there falls to the error path
    assign soc_mbox_req = soc_req_dv & soc_user_ok &
        (soc_req_addr inside {[MBOX_REG_START_ADDR:MBOX_REG_END_ADDR]});
    assign soc_reg_req = soc_req_dv &
        (soc_req_addr inside {[SOC_IFC_REG_START_ADDR:SOC_IFC_REG_END_ADDR]});

    // Each requester decodes to one target, so at most one collision exists per cycle
    assign mbox_collision = uc_mbox_req & soc_mbox_req;
    assign reg_collision = uc_reg_req & soc_reg_req;

    // The soc side takes a target when alone on it or when it holds the priority
    assign soc_wins_mbox = soc_mbox_req & (~mbox_collision | soc_has_priority);
    assign soc_wins_reg = soc_reg_req & (~reg_collision | soc_has_priority);
    assign uc_owns_mbox = uc_mbox_req & ~soc_wins_mbox;
    assign uc_owns_reg = uc_reg_req & ~soc_wins_reg;

    // The flag flips only when a collision cycle completes, so a held winner keeps the grant
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            soc_has_priority <= 1'b0;
        end else if ((mbox_collision & ~mbox_req_hold) | (reg_collision & ~reg_req_hold)) begin
            soc_has_priority <= ~soc_has_priority;
        end
    end

    // Mailbox strobes and fields follow the owner of the mailbox this cycle
    assign mbox_req_dv = soc_wins_mbox | (uc_mbox_reg_req & ~soc_wins_mbox);
    assign mbox_dir_req_dv = uc_mbox_dir_req & ~soc_wins_mbox;
    assign mbox_req_addr = soc_wins_mbox ? soc_req_addr : uc_req_addr;
    assign mbox_req_wdata = soc_wins_mbox ? soc_req_wdata : uc_req_wdata;
    assign mbox_req_write = soc_wins_mbox ? soc_req_write : uc_req_write;
    assign mbox_req_user = soc_wins_mbox ? soc_req_user : UC_USER;

    // The register block sees the winner of its own window
    assign reg_req_dv = uc_reg_req | soc_reg_req;
    assign reg_req_addr = soc_wins_reg ? soc_req_addr : uc_req_addr;
    assign reg_req_wdata = soc_wins_reg ? soc_req_wdata : uc_req_wdata;
    assign reg_req_write = soc_wins_reg ? soc_req_write : uc_req_write;

    // The AND/OR return mux lets only the owner of a target see its data
    assign uc_rdata = ({SOC_IFC_DATA_W{uc_owns_mbox}} & mbox_rdata) |
                      ({SOC_IFC_DATA_W{uc_owns_reg}} & reg_rdata);
    assign soc_rdata = ({SOC_IFC_DATA_W{soc_wins_mbox}} & mbox_rdata) |
                       ({SOC_IFC_DATA_W{soc_wins_reg}} & reg_rdata);

    // A loser waits on the collision and an owner waits on its target
    assign uc_req_hold = (uc_mbox_req & ~uc_owns_mbox) | (uc_reg_req & ~uc_owns_reg) |
                         (uc_owns_mbox & mbox_req_hold) | (uc_owns_reg & reg_req_hold);
    assign soc_req_hold = (soc_mbox_req & ~soc_wins_mbox) | (soc_reg_req & ~soc_wins_reg) |
                          (soc_wins_mbox & mbox_req_hold) | (soc_wins_reg & reg_req_hold);

    // Target errors go to the owner while unmapped or refused requests fail at once
    assign uc_error = (uc_owns_mbox & mbox_error) | (uc_owns_reg & reg_error) |
                      (uc_req_dv & ~(uc_mbox_req | uc_reg_req));
    assign soc_error = (soc_wins_mbox & mbox_error) | (soc_wins_reg & reg_error) |
                       (soc_req_dv & ~(soc_mbox_req | soc_reg_req));

endmodule

// File: hdl/soc_ifc_csr_pkg.sv
package soc_ifc_csr_pkg;

    // Byte offset of a register inside its window
    typedef logic [7:0] csr_offset_t;

    // Mailbox register window layout
    localparam csr_offset_t MBOX_LOCK_OFFSET = 8'h00;
    // Owner of the lock, read-only from both requesters
    localparam csr_offset_t MBOX_USER_OFFSET = 8'h04;

    // Depth of the mailbox SRAM in words and the index that selects one word
    localparam int MBOX_DEPTH = 256;
    typedef logic [$clog2(MBOX_DEPTH)-1:0] mbox_idx_t;

    // Register block layout, four scratch words followed by five valid-user words
    localparam int REG_NUM_SCRATCH = 4;
    localparam csr_offset_t REG_SCRATCH_OFFSET = 8'h00;
    localparam csr_offset_t REG_VALID_USER_OFFSET = 8'h10;

    // Every valid-user word starts out as all ones
    localparam logic [31:0] VALID_USER_RESET = 32'hFFFF_FFFF;

    // Mailbox lock state, the encoding is the bit returned on a lock read
    typedef enum logic {
        MBOX_UNLOCKED = 1'b0,
        MBOX_LOCKED = 1'b1
    } mbox_lock_e;

endpackage

// File: hdl/soc_ifc_mbox.sv
`timescale 1ns/1ps

module soc_ifc_mbox import soc_ifc_pkg::*, soc_ifc_csr_pkg::*; (
    input  logic clk,
    input  logic rst_b,
    input  logic mbox_req_dv,
    input  logic mbox_dir_req_dv,
    input  soc_ifc_addr_t addr,
    input  soc_ifc_data_t wdata,
    input  logic write,
    input  soc_ifc_user_t user,
    output logic hold,
    output soc_ifc_data_t rdata,
    output logic error
);

    mbox_lock_e lock_q;
    soc_ifc_user_t owner_q;
    logic rd_pending;
    soc_ifc_data_t rdata_q;
    soc_ifc_data_t sram [MBOX_DEPTH];

    csr_offset_t offset;
    mbox_idx_t dir_idx;
    logic dir_rd;
    logic dir_wr;
    logic lock_rd;
    logic lock_wr;
    logic user_hit;
    logic owner_match;

    // Byte offset in the register window and word index in the direct window
    assign offset = addr[7:0];
    assign dir_idx = addr[$bits(mbox_idx_t)+1:2];

    assign dir_rd = mbox_dir_req_dv & ~write;
    assign dir_wr = mbox_dir_req_dv & write;
    assign lock_rd = mbox_req_dv & ~write & (offset == MBOX_LOCK_OFFSET);
    assign lock_wr = mbox_req_dv & write & (offset == MBOX_LOCK_OFFSET);
    assign user_hit = offset == MBOX_USER_OFFSET;

    // Only the requester that took the lock may release it
    assign owner_match = (lock_q == MBOX_LOCKED) & (user == owner_q);

    // A direct read spends its first cycle fetching the word
    assign hold = dir_rd & ~rd_pending;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= hold;
        end
    end

    // SRAM array with a registered read port
    always_ff @(posedge clk) begin
        if (hold) begin
            rdata_q <= sram[dir_idx];
        end
        if (dir_wr) begin
            sram[dir_idx] <= wdata;
        end
    end

    // Read-to-lock, the read that finds the lock free takes it for the caller
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            lock_q <= MBOX_UNLOCKED;
            owner_q <= '0;
        end else if (lock_rd && lock_q == MBOX_UNLOCKED) begin
            lock_q <= MBOX_LOCKED;
            owner_q <= user;
        end else if (lock_wr && owner_match && !wdata[0]) begin
            lock_q <= MBOX_UNLOCKED;
        end
    end

    // The lock read returns the state seen before this access takes effect
    always_comb begin
        rdata = '0;
        if (dir_rd && rd_pending) begin
            rdata = rdata_q;
        end else if (lock_rd) begin
            rdata = {{(SOC_IFC_DATA_W-1){1'b0}}, lock_q == MBOX_LOCKED};
        end else if (mbox_req_dv && !write && user_hit) begin
            rdata = owner_q;
        end
    end

    // Writes to the owner word, foreign lock writes and unused offsets all fail
    assign error = (mbox_req_dv & write & user_hit) |
                   (lock_wr & ~owner_match) |
                   (mbox_req_dv & (offset != MBOX_LOCK_OFFSET) & ~user_hit);

endmodule

// File: hdl/soc_ifc_pkg.sv
package soc_ifc_pkg;

    // Widths of the request fields that both requesters and every target share
    localparam int SOC_IFC_ADDR_W = 18;
    localparam int SOC_IFC_DATA_W = 32;
    localparam int SOC_IFC_USER_W = 32;

    // Byte address, data word and user attribute of one access
    typedef logic [SOC_IFC_ADDR_W-1:0] soc_ifc_addr_t;
    typedef logic [SOC_IFC_DATA_W-1:0] soc_ifc_data_t;
    typedef logic [SOC_IFC_USER_W-1:0] soc_ifc_user_t;

    // Mailbox register window with the lock and owner words
    localparam soc_ifc_addr_t MBOX_REG_START_ADDR = 18'h0_0000;
    localparam soc_ifc_addr_t MBOX_REG_END_ADDR = 18'h0_00FF;

    // Mailbox direct memory window, 256 words of SRAM, open to uc only
    localparam soc_ifc_addr_t MBOX_DIR_START_ADDR = 18'h1_0000;
    localparam soc_ifc_addr_t MBOX_DIR_END_ADDR = 18'h1_03FF;

    // Register block with scratch and valid-user words
    localparam soc_ifc_addr_t SOC_IFC_REG_START_ADDR = 18'h3_0000;
    localparam soc_ifc_addr_t SOC_IFC_REG_END_ADDR = 18'h3_00FF;

    // A soc mailbox request must match one of these user words
    localparam int NUM_VALID_USERS = 5;

endpackage

// File: hdl/soc_ifc_regs.sv
`timescale 1ns/1ps

module soc_ifc_regs import soc_ifc_pkg::*, soc_ifc_csr_pkg::*; (
    input  logic clk,
    input  logic rst_b,
    input  logic reg_req_dv,
    input  soc_ifc_addr_t addr,
    input  soc_ifc_data_t wdata,
    input  logic write,
    output logic hold,
    output soc_ifc_data_t rdata,
    output logic error,
    output soc_ifc_user_t [NUM_VALID_USERS-1:0] valid_users
);

    soc_ifc_data_t scratch_q [REG_NUM_SCRATCH];
    logic [REG_NUM_SCRATCH-1:0] scratch_sel;
    logic [NUM_VALID_USERS-1:0] user_sel;
    logic [5:0] word;

    // Word number within the register window
    assign word = addr[7:2];

    always_comb begin
        for (int i = 0; i < REG_NUM_SCRATCH; i++) begin
            scratch_sel[i] = reg_req_dv & (word == REG_SCRATCH_OFFSET[7:2] + 6'(i));
        end
        for (int j = 0; j < NUM_VALID_USERS; j++) begin
            user_sel[j] = reg_req_dv & (word == REG_VALID_USER_OFFSET[7:2] + 6'(j));
        end
    end

    // Every access here is single cycle
    assign hold = 1'b0;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < REG_NUM_SCRATCH; i++) begin
                scratch_q[i] <= '0;
            end
            for (int j = 0; j < NUM_VALID_USERS; j++) begin
                valid_users[j] <= VALID_USER_RESET;
            end
        end else if (write) begin
            for (int i = 0; i < REG_NUM_SCRATCH; i++) begin
                if (scratch_sel[i]) scratch_q[i] <= wdata;
            end
            for (int j = 0; j < NUM_VALID_USERS; j++) begin
                if (user_sel[j]) valid_users[j] <= wdata;
            end
        end
    end

    // Selects are one-hot, so an OR of the gated words forms the read mux
    always_comb begin
        rdata = '0;
        if (!write) begin
            for (int i = 0; i < REG_NUM_SCRATCH; i++) begin
                rdata |= {SOC_IFC_DATA_W{scratch_sel[i]}} & scratch_q[i];
            end
            for (int j = 0; j < NUM_VALID_USERS; j++) begin
                rdata |= {SOC_IFC_DATA_W{user_sel[j]}} & valid_users[j];
            end
        end
    end

    // Holes in the window answer with error
    assign error = reg_req_dv & ~(|scratch_sel) & ~(|user_sel);

endmodule

// File: hdl/soc_ifc_top.sv
`timescale 1ns/1ps

module soc_ifc_top import soc_ifc_pkg::*; (
    input  logic clk,
    input  logic rst_b,

    // Internal microcontroller port
    input  logic uc_req_dv,
    input  soc_ifc_addr_t uc_req_addr,
    input  soc_ifc_data_t uc_req_wdata,
    input  logic uc_req_write,
    output logic uc_req_hold,
    output soc_ifc_data_t uc_rdata,
    output logic uc_error,

    // External SoC port
    input  logic soc_req_dv,
    input  soc_ifc_addr_t soc_req_addr,
    input  soc_ifc_data_t soc_req_wdata,
    input  logic soc_req_write,
    input  soc_ifc_user_t soc_req_user,
    output logic soc_req_hold,
    output soc_ifc_data_t soc_rdata,
    output logic soc_error
);

    soc_ifc_user_t [NUM_VALID_USERS-1:0] valid_users;

    // Arbiter to mailbox
    logic mbox_req_dv;
    logic mbox_dir_req_dv;
    soc_ifc_addr_t mbox_req_addr;
    soc_ifc_data_t mbox_req_wdata;
    logic mbox_req_write;
    soc_ifc_user_t mbox_req_user;
    logic mbox_req_hold;
    soc_ifc_data_t mbox_rdata;
    logic mbox_error;

    // Arbiter to register block
    logic reg_req_dv;
    soc_ifc_addr_t reg_req_addr;
    soc_ifc_data_t reg_req_wdata;
    logic reg_req_write;
    logic reg_req_hold;
    soc_ifc_data_t reg_rdata;
    logic reg_error;

    soc_ifc_arb arb_i (.*);

    soc_ifc_mbox mbox_i (
        .clk(clk), .rst_b(rst_b),
        .mbox_req_dv(mbox_req_dv), .mbox_dir_req_dv(mbox_dir_req_dv),
        .addr(mbox_req_addr), .wdata(mbox_req_wdata),
        .write(mbox_req_write), .user(mbox_req_user),
        .hold(mbox_req_hold), .rdata(mbox_rdata), .error(mbox_error)
    );

    // The register block also supplies the user list to the arbiter
    soc_ifc_regs regs_i (
        .clk(clk), .rst_b(rst_b), .reg_req_dv(reg_req_dv),
        .addr(reg_req_addr), .wdata(reg_req_wdata), .write(reg_req_write),
        .hold(reg_req_hold), .rdata(reg_rdata), .error(reg_error),
        .valid_users(valid_users)
    );

endmodule

// File: soc_ifc.f
hdl/soc_ifc_pkg.sv
hdl/soc_ifc_csr_pkg.sv
hdl/soc_ifc_arb.sv
hdl/soc_ifc_mbox.sv
hdl/soc_ifc_regs.sv
hdl/soc_ifc_top.sv
dv/soc_ifc_checker.sv
dv/soc_ifc_tb.sv
